// ==== hw/miss_cfg.svh ====
/*
  Cache geometry for the miss handling unit.
  Base sizes and the address field widths derived from them.
*/

`ifndef MISS_CFG_SVH
`define MISS_CFG_SVH

`define CACHE_WAYS        4
`define CACHE_SETS        16
`define CACHE_ADDR_W      20
`define CACHE_WORD_BYTES  4
`define CACHE_BLOCK_WORDS 4

// address layout is {tag, index, block offset}.
`define CACHE_WAY_W    $clog2(`CACHE_WAYS)
`define CACHE_INDEX_W  $clog2(`CACHE_SETS)
`define CACHE_OFFSET_W ($clog2(`CACHE_WORD_BYTES) + $clog2(`CACHE_BLOCK_WORDS))
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

// ==== hw/miss_pkg.sv ====
/*
  Miss handling unit types.
  Opcodes, DMA commands, FSM states and the packed structs that
  carry requests, metadata and DMA commands between blocks.
*/

`include "miss_cfg.svh"

package miss_pkg;

  typedef enum logic [2:0] {
    OP_LD,
    OP_ST,
    OP_AFL,
    OP_AINV,
    OP_AFLINV,
    OP_TAGFL
  } miss_op_e;

  typedef enum logic [2:0] {
    DMA_NOP,
    DMA_SEND_FILL_ADDR,
    DMA_SEND_EVICT_ADDR,
    DMA_SEND_EVICT_DATA,
    DMA_GET_FILL_DATA
  } dma_cmd_e;

  typedef enum logic [3:0] {
    ST_START,
    ST_FLUSH,
    ST_FILL_ADDR,
    ST_EVICT_ADDR,
    ST_EVICT_DATA,
    ST_FILL_DATA,
    ST_RECOVER,
    ST_DONE
  } miss_state_e;

  typedef struct packed {
    logic                                        valid;
    miss_op_e                                    op;
    logic [`CACHE_ADDR_W-1:0]                    addr;
    logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0]    tags;
    logic [`CACHE_WAYS-1:0]                      valid_bits;
    logic [`CACHE_WAYS-1:0]                      tag_hit;
    logic [`CACHE_WAY_W-1:0]                     tag_hit_way;
  } miss_req_s;

  typedef struct packed {
    logic [`CACHE_WAYS-1:0] dirty;
    logic [`CACHE_WAYS-2:0] lru;
  } stat_info_s;

  typedef struct packed {
    logic                    valid;
    logic [`CACHE_TAG_W-1:0] tag;
  } tag_info_s;

  typedef struct packed {
    logic is_flush;
    logic is_inv;
    logic is_tagfl;
    logic is_store;
    logic force_evict;
    logic no_evict;
  } route_s;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]   tag;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_WAY_W-1:0]   way;
  } addr_fields_s;

  typedef struct packed {
    dma_cmd_e                 cmd;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_WAY_W-1:0]  way;
  } dma_req_s;

  typedef struct packed {
    logic                                 stat_v;
    logic                                 stat_w;
    logic [`CACHE_INDEX_W-1:0]            index;
    stat_info_s                           stat_data;
    stat_info_s                           stat_mask;
    logic                                 tag_v;
    logic                                 tag_w;
    tag_info_s [`CACHE_WAYS-1:0]          tag_data;
    tag_info_s [`CACHE_WAYS-1:0]          tag_mask;
  } meta_wr_s;

endpackage

// ==== hw/miss_decode.sv ====
/*
  Request decoder for the miss handling unit.
  Turns the opcode into route flags and cuts the address into
  tag, set index and the way addressed by a TAGFL.
*/

`timescale 1ns/100ps

`include "miss_cfg.svh"

module miss_decode
  import miss_pkg::*;
(
  input  miss_req_s    req_i,
  output route_s       route_o,
  output addr_fields_s fields_o
);

  localparam int OFFSET_W = `CACHE_OFFSET_W;
  localparam int INDEX_W  = `CACHE_INDEX_W;
  localparam int TAG_W    = `CACHE_TAG_W;
  localparam int WAY_W    = `CACHE_WAY_W;

  always_comb begin
    route_o = '0;
    case (req_i.op)
      OP_ST: begin
        route_o.is_store = 1'b1;
      end
      OP_AFL: begin
        route_o.is_flush    = 1'b1;
        route_o.force_evict = 1'b1;
      end
      OP_AINV: begin
        route_o.is_flush = 1'b1;
        route_o.is_inv   = 1'b1;
        route_o.no_evict = 1'b1;
      end
      OP_AFLINV: begin
        route_o.is_flush    = 1'b1;
        route_o.is_inv      = 1'b1;
        route_o.force_evict = 1'b1;
      end
      OP_TAGFL: begin
        route_o.is_flush = 1'b1;
        route_o.is_tagfl = 1'b1;
      end
      default: begin
        // a plain load takes the default fill route.
        route_o = '0;
      end
    endcase
  end

  // for TAGFL the low tag bits name the way directly.
  assign fields_o.tag   = req_i.addr[OFFSET_W+INDEX_W +: TAG_W];
  assign fields_o.index = req_i.addr[OFFSET_W +: INDEX_W];
  assign fields_o.way   = req_i.addr[OFFSET_W+INDEX_W +: WAY_W];

  // the tag-verify stage only sends defined opcodes.
  always_comb begin
    assert final (!req_i.valid ||
                  req_i.op inside {OP_LD, OP_ST, OP_AFL, OP_AINV, OP_AFLINV, OP_TAGFL})
      else $error("miss_decode: illegal opcode %0d", req_i.op);
  end

endmodule

// ==== hw/victim_select.sv ====
/*
  Victim way selection.
  Takes the lowest invalid way if there is one, otherwise walks the
  pseudo-LRU tree. Also forms the MRU update bits for a given way.
*/

`timescale 1ns/100ps

`include "miss_cfg.svh"

module victim_select (
  input  logic [`CACHE_WAYS-1:0]  valid_i,
  input  logic [`CACHE_WAYS-2:0]  lru_i,
  input  logic [`CACHE_WAY_W-1:0] way_i,
  output logic [`CACHE_WAY_W-1:0] victim_o,
  output logic [`CACHE_WAYS-2:0]  mru_bits_o,
  output logic [`CACHE_WAYS-2:0]  mru_mask_o
);

  localparam int WAYS  = `CACHE_WAYS;
  localparam int WAY_W = `CACHE_WAY_W;

  logic [WAY_W-1:0] inv_way;
  logic             inv_found;
  logic [WAY_W-1:0] lru_way;

  // the downward loop leaves the lowest invalid index in inv_way.
  always_comb begin
    inv_way   = '0;
    inv_found = 1'b0;
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_way   = WAY_W'(i);
        inv_found = 1'b1;
      end
    end
  end

  // tree nodes are heap ordered. Node n has children 2n+1 (lower) and 2n+2 (upper),
  // and a set bit steers toward the upper child.
  always_comb begin
    int node;
    node    = 0;
    lru_way = '0;
    for (int l = 0; l < WAY_W; l++) begin
      lru_way[WAY_W-1-l] = lru_i[node];
      node = 2 * node + 1 + int'(lru_i[node]);
    end
  end

  assign victim_o = inv_found ? inv_way : lru_way;

  // every node on the path to way_i is pointed away from it, the rest stay masked off.
  always_comb begin
    int node;
    node       = 0;
    mru_bits_o = '0;
    mru_mask_o = '0;
    for (int l = 0; l < WAY_W; l++) begin
      mru_bits_o[node] = ~way_i[WAY_W-1-l];
      mru_mask_o[node] = 1'b1;
      node = 2 * node + 1 + int'(way_i[WAY_W-1-l]);
    end
  end

  // a valid line must never be replaced while an empty way is available.
  always_comb begin
    assert final (&valid_i || !valid_i[victim_o])
      else $error("victim_select: valid way %0d chosen over an invalid way", victim_o);
  end

endmodule

// ==== hw/miss_fsm.sv ====
/*
  Miss handling state machine.
  Sequences fill, evict and flush handling, drives the DMA command
  and address, and keeps the chosen and flush ways.
*/

`timescale 1ns/100ps

`include "miss_cfg.svh"

module miss_fsm
  import miss_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  miss_req_s               req_i,
  input  route_s                  route_i,
  input  addr_fields_s            fields_i,
  input  stat_info_s              stat_i,
  input  logic [`CACHE_WAY_W-1:0] victim_i,
  input  logic                    dma_done_i,
  input  logic                    ack_i,
  output miss_state_e             state_o,
  output logic [`CACHE_WAY_W-1:0] chosen_way_o,
  output logic [`CACHE_WAY_W-1:0] flush_way_o,
  output dma_req_s                dma_o,
  output logic                    recover_o,
  output logic                    done_o
);

  localparam int WAY_W    = `CACHE_WAY_W;
  localparam int OFFSET_W = `CACHE_OFFSET_W;
  localparam int ADDR_W   = `CACHE_ADDR_W;

  miss_state_e      state_r;
  miss_state_e      state_n;
  logic [WAY_W-1:0] chosen_way_r;
  logic [WAY_W-1:0] chosen_way_n;
  logic [WAY_W-1:0] flush_way_r;
  logic [WAY_W-1:0] flush_way_n;
  logic [WAY_W-1:0] flush_pick;
  logic [WAY_W-1:0] dma_way;
  logic [ADDR_W-1:0] fill_addr;
  logic [ADDR_W-1:0] evict_addr;
  logic             victim_evict;
  logic             flush_evict;

  // the way registers follow their live pick while the owning state is active.
  assign flush_pick   = route_i.is_tagfl ? fields_i.way : req_i.tag_hit_way;
  assign chosen_way_n = (state_r == ST_FILL_ADDR) ? victim_i : chosen_way_r;
  assign flush_way_n  = (state_r == ST_FLUSH) ? flush_pick : flush_way_r;
  assign dma_way      = route_i.is_flush ? flush_way_n : chosen_way_n;

  // block addresses, always aligned to the start of the block.
  assign fill_addr  = {fields_i.tag, fields_i.index, {OFFSET_W{1'b0}}};
  assign evict_addr = {req_i.tags[dma_way], fields_i.index, {OFFSET_W{1'b0}}};

  assign victim_evict = stat_i.dirty[chosen_way_n] & req_i.valid_bits[chosen_way_n];
  assign flush_evict  = req_i.valid_bits[flush_way_n] & ~route_i.no_evict &
                        (stat_i.dirty[flush_way_n] | route_i.force_evict);

  always_comb begin
    state_n    = state_r;
    dma_o.cmd  = DMA_NOP;
    dma_o.addr = '0;
    dma_o.way  = dma_way;
    case (state_r)
      ST_START: begin
        if (req_i.valid) begin
          state_n = route_i.is_flush ? ST_FLUSH : ST_FILL_ADDR;
        end
      end
      ST_FLUSH: begin
        // metadata is written this cycle by meta_write.
        state_n = flush_evict ? ST_EVICT_ADDR : ST_RECOVER;
      end
      ST_FILL_ADDR: begin
        dma_o.cmd  = DMA_SEND_FILL_ADDR;
        dma_o.addr = fill_addr;
        if (dma_done_i) begin
          state_n = victim_evict ? ST_EVICT_ADDR : ST_FILL_DATA;
        end
      end
      ST_EVICT_ADDR: begin
        dma_o.cmd  = DMA_SEND_EVICT_ADDR;
        dma_o.addr = evict_addr;
        if (dma_done_i) begin
          state_n = ST_EVICT_DATA;
        end
      end
      ST_EVICT_DATA: begin
        dma_o.cmd  = DMA_SEND_EVICT_DATA;
        dma_o.addr = evict_addr;
        if (dma_done_i) begin
          state_n = route_i.is_flush ? ST_RECOVER : ST_FILL_DATA;
        end
      end
      ST_FILL_DATA: begin
        dma_o.cmd  = DMA_GET_FILL_DATA;
        dma_o.addr = fill_addr;
        if (dma_done_i) begin
          state_n = ST_RECOVER;
        end
      end
      ST_RECOVER: begin
        state_n = ST_DONE;
      end
      ST_DONE: begin
        if (ack_i) begin
          state_n = ST_START;
        end
      end
      default: begin
        state_n = ST_START;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= ST_START;
      chosen_way_r <= '0;
      flush_way_r  <= '0;
    end else begin
      state_r      <= state_n;
      chosen_way_r <= chosen_way_n;
      flush_way_r  <= flush_way_n;
    end
  end

  assign state_o      = state_r;
  assign chosen_way_o = chosen_way_r;
  assign flush_way_o  = flush_way_n;
  assign recover_o    = (state_r == ST_RECOVER);
  assign done_o       = (state_r == ST_DONE);

  // the DMA engine sees a stable command until it signals done.
  a_dma_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (dma_o.cmd != DMA_NOP && !dma_done_i) |=> $stable(dma_o.cmd))
    else $error("miss_fsm: DMA command changed before done");

endmodule

// ==== hw/meta_write.sv ====
/*
  Tag and stat memory write formation.
  Issues the stat read on a new request, clears dirty and valid
  bits for flushes, and installs the new line after a fill.
*/

`timescale 1ns/100ps

`include "miss_cfg.svh"

module meta_write
  import miss_pkg::*;
(
  input  miss_state_e             state_i,
  input  miss_req_s               req_i,
  input  route_s                  route_i,
  input  addr_fields_s            fields_i,
  input  logic [`CACHE_WAY_W-1:0] chosen_way_i,
  input  logic [`CACHE_WAY_W-1:0] flush_way_i,
  input  logic [`CACHE_WAYS-2:0]  mru_bits_i,
  input  logic [`CACHE_WAYS-2:0]  mru_mask_i,
  input  logic                    dma_done_i,
  output meta_wr_s                meta_o
);

  localparam int WAYS  = `CACHE_WAYS;
  localparam int TAG_W = `CACHE_TAG_W;

  logic [WAYS-1:0] chosen_oh;
  logic [WAYS-1:0] flush_oh;

  assign chosen_oh = WAYS'(1) << chosen_way_i;
  assign flush_oh  = WAYS'(1) << flush_way_i;

  always_comb begin
    meta_o       = '0;
    meta_o.index = fields_i.index;
    case (state_i)
      ST_START: begin
        // stat data comes back in the following cycle.
        meta_o.stat_v = req_i.valid;
      end
      ST_FLUSH: begin
        // only the dirty bit of the flushed way is touched, lru stays.
        meta_o.stat_v          = 1'b1;
        meta_o.stat_w          = 1'b1;
        meta_o.stat_mask.dirty = flush_oh;
        meta_o.tag_v           = 1'b1;
        meta_o.tag_w           = 1'b1;
        for (int i = 0; i < WAYS; i++) begin
          meta_o.tag_mask[i].valid = route_i.is_inv & flush_oh[i];
        end
      end
      ST_FILL_DATA: begin
        // the new line becomes MRU, and dirty if a store brought it in.
        meta_o.stat_v          = dma_done_i;
        meta_o.stat_w          = 1'b1;
        meta_o.stat_data.dirty = {WAYS{route_i.is_store}};
        meta_o.stat_data.lru   = mru_bits_i;
        meta_o.stat_mask.dirty = chosen_oh;
        meta_o.stat_mask.lru   = mru_mask_i;
        meta_o.tag_v           = dma_done_i;
        meta_o.tag_w           = 1'b1;
        for (int i = 0; i < WAYS; i++) begin
          meta_o.tag_data[i].valid = 1'b1;
          meta_o.tag_data[i].tag   = fields_i.tag;
          meta_o.tag_mask[i].valid = chosen_oh[i];
          meta_o.tag_mask[i].tag   = {TAG_W{chosen_oh[i]}};
        end
      end
      default: begin
        meta_o.stat_v = 1'b0;
      end
    endcase
  end

  // tag memory writes belong to the flush and fill states only.
  always_comb begin
    assert final (!meta_o.tag_w || state_i inside {ST_FLUSH, ST_FILL_DATA})
      else $error("meta_write: tag write in state %s", state_i.name());
  end

endmodule

// ==== hw/cache_miss_unit.sv ====
/*
  Cache miss handling unit.
  Accepts one miss or flush request at a time, picks a victim,
  runs the DMA sequence and updates the tag and stat memories.
*/

`timescale 1ns/100ps

`include "miss_cfg.svh"

module cache_miss_unit
  import miss_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  miss_req_s               req_i,
  input  stat_info_s              stat_i,
  input  logic                    dma_done_i,
  input  logic                    ack_i,
  output dma_req_s                dma_o,
  output meta_wr_s                meta_o,
  output logic [`CACHE_WAY_W-1:0] chosen_way_o,
  output logic                    recover_o,
  output logic                    done_o
);

  route_s                  route;
  addr_fields_s            fields;
  miss_state_e             state;
  logic [`CACHE_WAY_W-1:0] victim;
  logic [`CACHE_WAY_W-1:0] flush_way;
  logic [`CACHE_WAYS-2:0]  mru_bits;
  logic [`CACHE_WAYS-2:0]  mru_mask;

  miss_decode i_miss_decode (
    .req_i    (req_i),
    .route_o  (route),
    .fields_o (fields)
  );

  // MRU bits are built for the registered chosen way used in the fill write.
  victim_select i_victim_select (
    .valid_i    (req_i.valid_bits),
    .lru_i      (stat_i.lru),
    .way_i      (chosen_way_o),
    .victim_o   (victim),
    .mru_bits_o (mru_bits),
    .mru_mask_o (mru_mask)
  );

  miss_fsm i_miss_fsm (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .route_i      (route),
    .fields_i     (fields),
    .stat_i       (stat_i),
    .victim_i     (victim),
    .dma_done_i   (dma_done_i),
    .ack_i        (ack_i),
    .state_o      (state),
    .chosen_way_o (chosen_way_o),
    .flush_way_o  (flush_way),
    .dma_o        (dma_o),
    .recover_o    (recover_o),
    .done_o       (done_o)
  );

  meta_write i_meta_write (
    .state_i      (state),
    .req_i        (req_i),
    .route_i      (route),
    .fields_i     (fields),
    .chosen_way_i (chosen_way_o),
    .flush_way_i  (flush_way),
    .mru_bits_i   (mru_bits),
    .mru_mask_i   (mru_mask),
    .dma_done_i   (dma_done_i),
    .meta_o       (meta_o)
  );

endmodule

// ==== tb/tb_cache_miss.sv ====
/*
  Testbench for the cache miss handling unit.
  Reads requests and expected results from a stimulus file, models the
  stat memory read, the DMA engine and the acknowledging stage, and
  checks the DMA sequence, the chosen way and the metadata writes.
*/

`timescale 1ns/100ps

`include "miss_cfg.svh"

module tb_cache_miss
  import miss_pkg::*;
();

  localparam int MAX_TESTS = 64;

  logic       clk_i;
  logic       reset_i;
  miss_req_s  req_i;
  stat_info_s stat_i;
  logic       dma_done_i;
  logic       ack_i;
  dma_req_s   dma_o;
  meta_wr_s   meta_o;
  logic [`CACHE_WAY_W-1:0] chosen_way_o;
  logic       recover_o;
  logic       done_o;

  string       names [MAX_TESTS];
  logic [31:0] stim [MAX_TESTS][18];
  int          num_tests;
  int          cycle_count;
  int          cycle_limit;

  cache_miss_unit i_cache_miss_unit (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .stat_i       (stat_i),
    .dma_done_i   (dma_done_i),
    .ack_i        (ack_i),
    .dma_o        (dma_o),
    .meta_o       (meta_o),
    .chosen_way_o (chosen_way_o),
    .recover_o    (recover_o),
    .done_o       (done_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // the limit is only armed once the stimulus file has been read.
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s %s: expected %h actual %h", test, what, expected, actual);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic load_stimulus();
    int    fd;
    int    cnt;
    string line;
    string name;
    logic [31:0] f [18];
    fd = $fopen("tb/miss_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the stimulus file tb/miss_stimulus.txt");
    end
    num_tests = 0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
      if (cnt != 18) begin
        stop_run({"malformed stimulus line: ", line});
      end
      names[num_tests] = name;
      for (int i = 1; i < 18; i++) begin
        stim[num_tests][i] = f[i];
      end
      num_tests++;
    end
    $fclose(fd);
  endtask

  // columns 1..10 are request inputs, 11..17 are the expected results.
  task automatic run_request(input int n);
    string       tn;
    logic [31:0] seq;
    logic [31:0] sdata;
    logic [31:0] smask;
    logic [31:0] tvmask;
    logic [31:0] tdata;
    logic [31:0] exp_index;
    logic [6:0]  sd;
    logic [6:0]  sm;
    logic [`CACHE_WAY_W-1:0] w;
    int  dma_delay;
    int  ack_delay;
    int  recover_count;
    int  stat_writes;
    int  tag_writes;
    bit  busy;
    bit  cmd_started;
    bit  stat_pending;
    bit  done_seen;
    bit  finished;
    tn = names[n];
    w  = stim[n][13][`CACHE_WAY_W-1:0];
    exp_index = (stim[n][2] >> `CACHE_OFFSET_W) % `CACHE_SETS;
    seq = '0;
    sdata = '0;
    smask = '0;
    tvmask = '0;
    tdata = '0;
    dma_delay = 0;
    ack_delay = 0;
    recover_count = 0;
    stat_writes = 0;
    tag_writes = 0;
    busy = 1'b0;
    cmd_started = 1'b0;
    stat_pending = 1'b0;
    done_seen = 1'b0;
    finished = 1'b0;
    @(negedge clk_i);
    req_i.valid       = 1'b1;
    req_i.op          = miss_op_e'(stim[n][1][2:0]);
    req_i.addr        = stim[n][2][`CACHE_ADDR_W-1:0];
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      req_i.tags[i] = stim[n][3+i][`CACHE_TAG_W-1:0];
    end
    req_i.valid_bits  = stim[n][7][`CACHE_WAYS-1:0];
    req_i.tag_hit     = stim[n][8][`CACHE_WAYS-1:0];
    req_i.tag_hit_way = stim[n][9][`CACHE_WAY_W-1:0];
    while (!finished) begin
      dma_done_i = 1'b0;
      ack_i      = 1'b0;
      if (stat_pending) begin
        stat_i = stim[n][10][6:0];
      end
      if (dma_o.cmd != DMA_NOP) begin
        if (!busy) begin
          busy        = 1'b1;
          cmd_started = 1'b1;
          seq         = (seq << 4) | 32'(dma_o.cmd);
          dma_delay   = int'($urandom_range(5, 0));
        end
        if (dma_delay == 0) begin
          dma_done_i = 1'b1;
          busy       = 1'b0;
        end else begin
          dma_delay--;
        end
      end
      if (done_seen) begin
        check_value(tn, "done held until ack", 32'd1, 32'(done_o));
      end
      if (done_o) begin
        if (!done_seen) begin
          done_seen = 1'b1;
          ack_delay = int'($urandom_range(3, 0));
          check_value(tn, "recover pulses", 32'd1, 32'(recover_count));
        end
        if (stim[n][1] < 2) begin
          check_value(tn, "chosen way", 32'(w), 32'(chosen_way_o));
        end
        if (ack_delay == 0) begin
          ack_i = 1'b1;
        end else begin
          ack_delay--;
        end
      end
      // outputs have settled well before the next rising edge.
      #10;
      if (cmd_started) begin
        // the fill way depends on the stat data driven at this falling edge.
        cmd_started = 1'b0;
        check_value(tn, "dma way", 32'(w), 32'(dma_o.way));
        if (dma_o.cmd == DMA_SEND_EVICT_ADDR) begin
          check_value(tn, "evict address", stim[n][12], 32'(dma_o.addr));
        end
        if (dma_o.cmd == DMA_SEND_FILL_ADDR) begin
          check_value(tn, "fill address", stim[n][2] & 32'hffff_fff0, 32'(dma_o.addr));
        end
      end
      if (meta_o.stat_v && !meta_o.stat_w) begin
        stat_pending = 1'b1;
        check_value(tn, "stat read index", exp_index, 32'(meta_o.index));
      end
      if (meta_o.stat_v && meta_o.stat_w) begin
        stat_writes++;
        sd    = meta_o.stat_data;
        sm    = meta_o.stat_mask;
        sdata = 32'(sd & sm);
        smask = 32'(sm);
        check_value(tn, "stat write index", exp_index, 32'(meta_o.index));
      end
      if (meta_o.tag_v && meta_o.tag_w) begin
        tag_writes++;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
          tvmask[i] = meta_o.tag_mask[i].valid;
        end
        tdata = 32'(meta_o.tag_data[w] & meta_o.tag_mask[w]);
        check_value(tn, "tag write index", exp_index, 32'(meta_o.index));
      end
      if (recover_o) begin
        recover_count++;
      end
      if (done_o && ack_i) begin
        finished = 1'b1;
      end else begin
        @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    req_i      = '0;
    stat_i     = '0;
    ack_i      = 1'b0;
    dma_done_i = 1'b0;
    check_value(tn, "dma sequence", stim[n][11], seq);
    check_value(tn, "stat writes", 32'd1, 32'(stat_writes));
    check_value(tn, "tag writes", 32'd1, 32'(tag_writes));
    check_value(tn, "stat data", stim[n][14], sdata);
    check_value(tn, "stat mask", stim[n][15], smask);
    check_value(tn, "tag valid mask", stim[n][16], tvmask);
    check_value(tn, "tag data", stim[n][17], tdata);
  endtask

  initial begin
    req_i       = '0;
    stat_i      = '0;
    dma_done_i  = 1'b0;
    ack_i       = 1'b0;
    reset_i     = 1'b1;
    cycle_count = 0;
    cycle_limit = 0;
    void'($urandom(32'hfff3961c));
    load_stimulus();
    cycle_limit = num_tests * 40;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    #10;
    check_value("reset", "done", 32'd0, 32'(done_o));
    check_value("reset", "recover", 32'd0, 32'(recover_o));
    check_value("reset", "dma command", 32'(DMA_NOP), 32'(dma_o.cmd));
    check_value("reset", "stat valid", 32'd0, 32'(meta_o.stat_v));
    check_value("reset", "tag valid", 32'd0, 32'(meta_o.tag_v));
    for (int n = 0; n < num_tests; n++) begin
      run_request(n);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== tb/miss_stimulus.txt ====
# name op addr tag0 tag1 tag2 tag3 valid hit hit_way stat (all hex after name)
# expected: dma_cmds evict_addr way stat_data stat_mask tag_valid_mask tag_data
ld_inv_way1    0 12353 111 222 333 444 d 0 0 78 14   0     1 01 13 2 1123
ld_inv_way0    0 abc07 111 222 333 444 6 0 0 00 14   0     0 03 0b 1 1abc
st_lru_dirty   1 5679a 111 222 333 444 f 0 0 21 1234 33390 2 24 25 4 1567
st_lru_clean   1 00010 111 222 333 444 f 0 0 6a 14   0     1 11 13 2 1000
ld_lru_dirty   0 fed4c 111 222 333 444 f 0 0 45 1234 44440 3 00 45 8 1fed
ld_inv_dirty   0 9abf0 111 222 333 444 b 0 0 27 14   0     2 04 25 4 19ab
st_inv_way3    1 76520 111 222 333 444 7 0 0 00 14   0     3 40 45 8 1765
afl_dirty      2 22230 111 222 333 444 f 2 1 10 23   22230 1 00 10 0 0000
afl_clean      2 33360 111 222 333 444 f 4 2 00 23   33360 2 00 20 0 0000
aflinv_dirty   4 44470 111 222 333 444 f 8 3 40 23   44470 3 00 40 8 0000
aflinv_clean   4 11120 111 222 333 444 f 1 0 00 23   11120 0 00 08 1 0000
aflinv_invalid 4 11120 111 222 333 444 e 1 0 08 0    0     0 00 08 1 0000
ainv_dirty     3 33350 111 222 333 444 f 4 2 20 0    0     2 00 20 4 0000
ainv_clean     3 22250 111 222 333 444 f 2 1 00 0    0     1 00 10 2 0000
tagfl_dirty    5 00160 111 222 333 444 f 0 3 10 23   22260 1 00 10 0 0000
tagfl_clean    5 00380 111 222 333 444 f 0 3 38 0    0     3 00 40 0 0000
st_lru_dirty_b 1 5679a 111 222 333 444 f 0 0 21 1234 33390 2 24 25 4 1567
ld_inv_way1_b  0 12353 111 222 333 444 d 0 0 78 14   0     1 01 13 2 1123

// ==== tb.f ====
+incdir+hw
hw/miss_pkg.sv
hw/miss_decode.sv
hw/victim_select.sv
hw/miss_fsm.sv
hw/meta_write.sv
hw/cache_miss_unit.sv
tb/tb_cache_miss.sv

// ==== Makefile ====
# Verilator build and run for the cache miss unit testbench.

TOP := tb_cache_miss

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
